/* project.f */
design/video_crop_pkg.sv
design/raster_measure.sv
design/crop_ctrl.sv
design/blank_gen.sv
design/mode_tracker.sv
design/video_crop_top.sv
verif/video_crop_properties.sv
verif/video_crop_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= video_crop_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* verif/video_crop_tb.sv */
// drives a fixed raster and random key events into the crop top level and checks it against a model
module video_crop_tb;
	import video_crop_pkg::*;

	localparam int h_total = 200;
	localparam int hs_len = 16;
	localparam int h_act_sta = 40;
	localparam int h_act_end = 180;
	localparam int v_total = 60;
	localparam int vs_len = 2;
	localparam int v_act_sta = 6;
	localparam int v_act_end = 56;
	localparam int h_step = 4;
	localparam int v_step = 1;
	localparam int h_force = 8;
	localparam int v_force = 3;
	localparam int h_lim = 4 * h_step;             // keeps every edge inside the line
	localparam int v_lim = 3 * v_step;
	localparam int num_frames = 12;
	localparam int cycle_limit = num_frames * 12000 + 2000;

	// geometry as the DUT measures it, counted from the end of sync
	localparam int hend = h_act_sta - hs_len;
	localparam int hsta = h_act_end - hs_len;
	localparam int hmax = h_total - hs_len;
	localparam int vend = v_act_sta - vs_len;
	localparam int vsta = v_act_end - vs_len;
	localparam int vmax = v_total - vs_len;

	localparam logic [7:0] key_codes [10] = '{key_reset, key_up, key_down, key_left, key_right,
		key_alt_l, key_alt_r, key_alt_l_up, key_alt_r_up, 8'h29};

	logic           clk_sys = 1'b0;
	logic           rst_n;
	video_sync_t    sync;
	key_event_t     key;
	logic [1:0]     res;
	logic           de;
	logic           hsync;
	logic           vsync;
	mode_snapshot_t snapshot;
	logic [6:0]     mode_changes;

	int hl, hr, vt, vb;                            // model crop
	logic alt_m;
	logic [1:0] m_res;
	int m_hsize, m_vsize, m_changes;
	logic vsize_seen;
	int h, v, frame, tick, cycles;
	int de_cnt, de_lines, errors, checks;
	logic [31:0] rng;

	video_crop_top #(
		.h_step  (h_step),
		.v_step  (v_step),
		.h_force (h_force),
		.v_force (v_force)
	) UUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.sync         (sync),
		.key          (key),
		.res          (res),
		.de           (de),
		.hsync        (hsync),
		.vsync        (vsync),
		.snapshot     (snapshot),
		.mode_changes (mode_changes)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int int_min(input int a, input int b);
		return (a < b) ? a : b;
	endfunction

	function automatic int int_max(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic drive_raster();
		sync.hsync_n = (h >= hs_len);
		sync.hblank  = !(h >= h_act_sta && h < h_act_end);
		sync.vsync_n = (v >= vs_len);
		sync.vblank  = !(v >= v_act_sta && v < v_act_end);
	endtask

	// one random event; moves that would leave the window turn around
	task automatic send_key();
		logic [7:0] code;
		logic [1:0] kind;
		logic is_h;
		int sgn, cur, lim, step;
		rng = xorshift32(rng);
		code = key_codes[rng % 10];
		kind = (rng[23:21] == 3'd0) ? 2'(rng[17:16] % 3) : key_kind_key;
		if (kind == key_kind_key) begin
			is_h = (code == key_left || code == key_right);
			if (is_h || code == key_up || code == key_down) begin
				sgn = (code == key_up || code == key_left) ? 1 : -1;
				step = is_h ? h_step : v_step;
				lim = is_h ? h_lim : v_lim;
				cur = is_h ? (alt_m ? hr : hl) : (alt_m ? vb : vt);
				if (cur + sgn * step > lim || cur + sgn * step < -lim) begin
					sgn = -sgn;
					if (is_h)
						code = (sgn > 0) ? key_left : key_right;
					else
						code = (sgn > 0) ? key_up : key_down;
				end
				cur = cur + sgn * step;
				if (is_h && alt_m)
					hr = cur;
				else if (is_h)
					hl = cur;
				else if (alt_m)
					vb = cur;
				else
					vt = cur;
			end else if (code == key_reset) begin
				hl = 0;
				hr = 0;
				vt = 0;
				vb = 0;
			end else if (code == key_alt_l || code == key_alt_r) begin
				alt_m = 1'b1;
			end else if (code == key_alt_l_up || code == key_alt_r_up) begin
				alt_m = 1'b0;
			end
		end
		key.level = ~key.level;
		key.kind  = kind;
		key.code  = code;
	endtask

	// expected de cycles in the line whose vcnt is c
	function automatic int line_width(input int c);
		int w, lo, hi;
		w = int_min(hsta + hr - 2, hmax - h_force) - int_max(hend + hl - 2, 8);
		lo = int_max(vend + vt - 1, 1);
		hi = int_min(vsta + vb - 1, vmax - v_force);
		if (c > lo && c < hi)
			return w;
		if (c == lo)
			return w - 1;                          // vertical flag drops at the first active cycle
		if (c == hi)
			return 1;
		return 0;
	endfunction

	task automatic sample_outputs();
		int lo, hi, vsz;
		check_value("hsync", hsync, !sync.hsync_n);
		check_value("vsync", vsync, !sync.vsync_n);
		if (rst_n) begin
			if (v == v_act_sta && h == 1) begin
				vsz = vsize_seen ? (v_act_end - v_act_sta) : 0;
				if (m_res != res || m_hsize != h_act_end - h_act_sta || m_vsize != vsz)
					m_changes++;
				m_res = res;
				m_hsize = h_act_end - h_act_sta;
				m_vsize = vsz;
				check_value("snapshot.crop.hbl_l", snapshot.crop.hbl_l, coord_t'(hl));
				check_value("snapshot.crop.hbl_r", snapshot.crop.hbl_r, coord_t'(hr));
				check_value("snapshot.crop.vbl_t", snapshot.crop.vbl_t, coord_t'(vt));
				check_value("snapshot.crop.vbl_b", snapshot.crop.vbl_b, coord_t'(vb));
				check_value("snapshot.hsize", snapshot.hsize, m_hsize);
				check_value("snapshot.vsize", snapshot.vsize, m_vsize);
				check_value("snapshot.res", snapshot.res, m_res);
			end
			check_value("mode_changes", mode_changes, 7'(m_changes));
		end
		if (de)
			de_cnt++;
		if (h == h_total - 1) begin
			if (frame >= 2)
				check_value("de cycles per line", de_cnt, line_width((v >= vs_len) ? v - 1 : 0));
			if (de_cnt > 0)
				de_lines++;
			de_cnt = 0;
			if (v == v_act_end) begin              // rest of the frame stays blank
				lo = int_max(vend + vt - 1, 1);
				hi = int_min(vsta + vb - 1, vmax - v_force);
				if (frame >= 2)
					check_value("de lines per frame", de_lines, hi - lo + 1);
				de_lines = 0;
			end
		end
	endtask

	initial begin
		rng = 32'd95166;
		rst_n = 1'b0;
		key = '0;
		res = 2'd0;
		{hl, hr, vt, vb} = '0;
		alt_m = 1'b0;
		m_res = 2'd0;
		{m_hsize, m_vsize, m_changes} = '0;
		vsize_seen = 1'b0;
		{h, v, frame, tick, cycles} = '0;
		{de_cnt, de_lines, errors, checks} = '0;
		drive_raster();
		while (frame < num_frames) begin
			@(posedge clk_sys);
			sample_outputs();
			#1;
			tick++;
			if (tick == 16)
				rst_n = 1'b1;
			h++;
			if (h == h_total) begin
				h = 0;
				v++;
				if (v == v_total) begin
					v = 0;
					frame++;
				end
			end
			if (v == v_act_end && rst_n)
				vsize_seen = 1'b1;                 // first frame blank rise seen
			drive_raster();
			if (h == 0 && v >= v_total - 2 && rst_n)
				send_key();                        // after the last vertical edge
			if (h == 0 && v == 30) begin
				rng = xorshift32(rng);
				if (rng[1:0] == 2'd0)
					res = rng[9:8];
			end
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* verif/video_crop_properties.sv */
// concurrent checks on the crop top level, attached to every video_crop_top instance by bind
module video_crop_properties
	import video_crop_pkg::*;
(
	input logic        clk_sys,
	input logic        rst_n,
	input video_sync_t sync,
	input logic        de,
	input logic        hsync,
	input logic        frame_start,
	input logic [6:0]  mode_changes
);

	// de register clears on the first reset edge
	assert property (@(posedge clk_sys) !rst_n |=> !de)
		else $error("de high after a reset cycle");

	// counter moves only on a frame start
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mode_changes != $past(mode_changes)) |-> $past(frame_start))
		else $error("mode_changes moved without frame_start");

	assert property (@(posedge clk_sys) hsync == ~sync.hsync_n)
		else $error("hsync is not the inverse of hsync_n");

endmodule

bind video_crop_top video_crop_properties u_props (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.sync         (sync),
	.de           (de),
	.hsync        (hsync),
	.frame_start  (frame_start),
	.mode_changes (mode_changes)
);

/* design/video_crop_top.sv */
// top of the crop block, measures the raster, applies key crop and drives de and active-high syncs
module video_crop_top
	import video_crop_pkg::*;
#(
	parameter int h_step  = 4,                     // pixels per left/right key
	parameter int v_step  = 1,                     // lines per up/down key
	parameter int h_force = 8,
	parameter int v_force = 3
) (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  video_sync_t    sync,
	input  key_event_t     key,
	input  logic [1:0]     res,
	output logic           de,
	output logic           hsync,
	output logic           vsync,
	output mode_snapshot_t snapshot,
	output logic [6:0]     mode_changes
);

	raster_geom_t geom;
	crop_t        crop;
	logic         frame_start;

	//////////////////////////////
	// producer
	//////////////////////////////

	raster_measure u_measure (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.sync        (sync),
		.geom        (geom),
		.frame_start (frame_start)
	);

	//////////////////////////////
	// crop offsets
	//////////////////////////////

	crop_ctrl #(
		.h_step (h_step),
		.v_step (v_step)
	) u_crop (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.key     (key),
		.crop    (crop)
	);

	//////////////////////////////
	// consumers
	//////////////////////////////

	blank_gen #(
		.h_force (h_force),
		.v_force (v_force)
	) u_blank (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sync    (sync),
		.geom    (geom),
		.crop    (crop),
		.de      (de),
		.hsync   (hsync),
		.vsync   (vsync)
	);

	mode_tracker u_mode (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.geom         (geom),
		.crop         (crop),
		.res          (res),
		.frame_start  (frame_start),
		.snapshot     (snapshot),
		.mode_changes (mode_changes)
	);

endmodule

/* design/mode_tracker.sv */
// latches crop and active size at each frame start and counts how often the video mode changes
module mode_tracker
	import video_crop_pkg::*;
(
	input  logic           clk_sys,
	input  logic           rst_n,
	input  raster_geom_t   geom,
	input  crop_t          crop,
	input  logic [1:0]     res,
	input  logic           frame_start,
	output mode_snapshot_t snapshot,
	output logic [6:0]     mode_changes
);

	logic mode_diff;

	// compare against the values held from the previous frame
	assign mode_diff = (snapshot.res != res)
		|| (snapshot.hsize != geom.hsize)
		|| (snapshot.vsize != geom.vsize);

	//////////////////////////////
	// frame start snapshot
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			snapshot     <= '0;
			mode_changes <= '0;
		end else if (frame_start) begin
			snapshot.crop  <= crop;
			snapshot.hsize <= geom.hsize;
			snapshot.vsize <= geom.vsize;
			snapshot.res   <= res;
			if (mode_diff)
				mode_changes <= mode_changes + 1'b1;  // wraps at 128
		end
	end

endmodule

/* design/blank_gen.sv */
// builds display enable from the crop-shifted and forced blanking, and passes the syncs active high
module blank_gen
	import video_crop_pkg::*;
#(
	parameter int h_force = 8,
	parameter int v_force = 3
) (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  video_sync_t  sync,
	input  raster_geom_t geom,
	input  crop_t        crop,
	output logic         de,
	output logic         hsync,
	output logic         vsync
);

	logic shbl;                                    // shifted hblank
	logic fhbl;                                    // forced hblank
	logic svbl;                                    // shifted vblank
	logic fvbl;                                    // forced vblank
	logic hbl;
	logic old_hbl;
	logic hbl_fall;

	coord_t shbl_clr;
	coord_t shbl_set;
	coord_t fhbl_set;
	coord_t svbl_clr;
	coord_t svbl_set;
	coord_t fvbl_set;

	//////////////////////////////
	// edge positions
	//////////////////////////////

	assign shbl_clr = geom.hend + crop.hbl_l - coord_t'(2);
	assign shbl_set = geom.hsta + crop.hbl_r - coord_t'(2);
	assign fhbl_set = geom.hmax - coord_t'(h_force);
	assign svbl_clr = geom.vend + crop.vbl_t - coord_t'(1);
	assign svbl_set = geom.vsta + crop.vbl_b - coord_t'(1);
	assign fvbl_set = geom.vmax - coord_t'(v_force);

	assign hbl      = fhbl | shbl | ~sync.hsync_n;
	assign hbl_fall = old_hbl & ~hbl;

	assign hsync = ~sync.hsync_n;                  // zero latency
	assign vsync = ~sync.vsync_n;

	//////////////////////////////
	// blank flags and de
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			shbl    <= 1'b1;
			fhbl    <= 1'b1;
			svbl    <= 1'b1;
			fvbl    <= 1'b1;
			old_hbl <= 1'b1;
			de      <= 1'b0;
		end else begin
			old_hbl <= hbl;

			if (geom.hcnt == shbl_clr)
				shbl <= 1'b0;
			if (geom.hcnt == shbl_set)
				shbl <= 1'b1;

			if (geom.hcnt == coord_t'(8))
				fhbl <= 1'b0;                      // fixed left margin
			if (geom.hcnt == fhbl_set)
				fhbl <= 1'b1;

			// vertical terms move once per line, at the start of active
			if (hbl_fall) begin
				if (geom.vcnt == svbl_clr)
					svbl <= 1'b0;
				if (geom.vcnt == svbl_set)
					svbl <= 1'b1;
				if (geom.vcnt == coord_t'(1))
					fvbl <= 1'b0;
				if (geom.vcnt == fvbl_set)
					fvbl <= 1'b1;
			end

			de <= ~hbl & ~svbl & ~fvbl;            // one cycle behind
		end
	end

endmodule

/* design/crop_ctrl.sv */
// turns keyboard events into the four crop offsets, arrows move an edge and alt picks the far one
module crop_ctrl
	import video_crop_pkg::*;
#(
	parameter int h_step = 4,
	parameter int v_step = 1
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  key_event_t key,
	output crop_t      crop
);

	localparam coord_t h_inc = coord_t'(h_step);
	localparam coord_t v_inc = coord_t'(v_step);

	logic old_level;
	logic alt;                                     // alt key held
	logic accept;

	//////////////////////////////
	// event detection
	//////////////////////////////

	// a new event shows as a level toggle, only key events are decoded
	assign accept = (old_level ^ key.level) && (key.kind == key_kind_key);

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			old_level <= 1'b0;
		else
			old_level <= key.level;
	end

	//////////////////////////////
	// offset update
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			crop <= '0;
			alt  <= 1'b0;
		end else if (accept) begin
			case (key.code)
				key_reset: begin
					crop <= '0;                    // back to full raster
				end
				key_up: begin
					if (alt)
						crop.vbl_b <= crop.vbl_b + v_inc;
					else
						crop.vbl_t <= crop.vbl_t + v_inc;
				end
				key_down: begin
					if (alt)
						crop.vbl_b <= crop.vbl_b - v_inc;
					else
						crop.vbl_t <= crop.vbl_t - v_inc;
				end
				key_left: begin
					if (alt)
						crop.hbl_r <= crop.hbl_r + h_inc;
					else
						crop.hbl_l <= crop.hbl_l + h_inc;
				end
				key_right: begin
					if (alt)
						crop.hbl_r <= crop.hbl_r - h_inc;
					else
						crop.hbl_l <= crop.hbl_l - h_inc;
				end
				key_alt_l, key_alt_r: begin
					alt <= 1'b1;                   // press
				end
				key_alt_l_up, key_alt_r_up: begin
					alt <= 1'b0;                   // release
				end
				default: begin
					alt <= alt;                    // other keys ignored
				end
			endcase
		end
	end

endmodule

/* design/raster_measure.sv */
// measures line and frame timing from the core syncs and blanks, feeds geometry to the crop logic
module raster_measure
	import video_crop_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  video_sync_t  sync,
	output raster_geom_t geom,
	output logic         frame_start
);

	logic old_hsync_n;
	logic old_vsync_n;
	logic old_hblank;
	logic old_fblank;

	logic fblank;
	logic hs_fall;
	logic vs_fall;
	logic hbl_fall;
	logic hbl_rise;
	logic fbl_fall;
	logic fbl_rise;

	//////////////////////////////
	// edge detection
	//////////////////////////////

	assign fblank   = sync.vblank | ~sync.vsync_n;  // frame blank includes vsync

	assign hs_fall  = old_hsync_n & ~sync.hsync_n;
	assign vs_fall  = old_vsync_n & ~sync.vsync_n;
	assign hbl_fall = old_hblank & ~sync.hblank;
	assign hbl_rise = ~old_hblank & sync.hblank;
	assign fbl_fall = old_fblank & ~fblank;
	assign fbl_rise = ~old_fblank & fblank;

	assign frame_start = fbl_fall;                 // first active line begins

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_hsync_n <= 1'b0;
			old_vsync_n <= 1'b0;
			old_hblank  <= 1'b0;
			old_fblank  <= 1'b0;                   // no start pulse out of reset
		end else begin
			old_hsync_n <= sync.hsync_n;
			old_vsync_n <= sync.vsync_n;
			old_hblank  <= sync.hblank;
			old_fblank  <= fblank;
		end
	end

	//////////////////////////////
	// counters and captures
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			geom <= '0;
		end else begin
			geom.hcnt <= geom.hcnt + 1'b1;
			if (!sync.hsync_n)
				geom.hcnt <= '0;                   // held during hsync

			if (hs_fall)
				geom.vcnt <= geom.vcnt + 1'b1;     // one line per hsync
			if (!sync.vsync_n)
				geom.vcnt <= '0;

			// horizontal edges
			if (hbl_fall)
				geom.hend <= geom.hcnt;
			if (hbl_rise) begin
				geom.hsta  <= geom.hcnt;
				geom.hsize <= geom.hcnt - geom.hend;  // active width
			end
			if (hs_fall)
				geom.hmax <= geom.hcnt;

			// vertical edges
			if (fbl_fall)
				geom.vend <= geom.vcnt;
			if (fbl_rise) begin
				geom.vsta  <= geom.vcnt;
				geom.vsize <= geom.vcnt - geom.vend;  // active height
			end
			if (vs_fall)
				geom.vmax <= geom.vcnt;
		end
	end

endmodule

/* design/video_crop_pkg.sv */
// shared coordinate width, key codes and bus structs, imported by every crop and blanking block
package video_crop_pkg;

	//////////////////////////////
	// coordinates
	//////////////////////////////

	localparam int coord_w = 12;                     // every counter and offset

	typedef logic [coord_w-1:0] coord_t;

	//////////////////////////////
	// video timing and keyboard
	//////////////////////////////

	typedef struct packed {
		logic hsync_n;                               // active low
		logic vsync_n;                               // active low
		logic hblank;
		logic vblank;
	} video_sync_t;

	typedef struct packed {
		logic       level;                           // toggles once per event
		logic [1:0] kind;
		logic [7:0] code;
	} key_event_t;

	localparam logic [1:0] key_kind_key = 2'd3;      // kind carrying key codes

	localparam logic [7:0] key_reset    = 8'h41;     // backspace, clears crop
	localparam logic [7:0] key_up       = 8'h4c;
	localparam logic [7:0] key_down     = 8'h4d;
	localparam logic [7:0] key_right    = 8'h4e;
	localparam logic [7:0] key_left     = 8'h4f;
	localparam logic [7:0] key_alt_l    = 8'h64;
	localparam logic [7:0] key_alt_r    = 8'h65;
	localparam logic [7:0] key_alt_l_up = 8'he4;     // release codes
	localparam logic [7:0] key_alt_r_up = 8'he5;

	//////////////////////////////
	// geometry and crop
	//////////////////////////////

	typedef struct packed {
		coord_t hcnt;                                // cycle in line
		coord_t vcnt;                                // line in frame
		coord_t hend;                                // hblank fall
		coord_t hsta;                                // hblank rise
		coord_t hmax;                                // line length
		coord_t vend;                                // frame blank fall
		coord_t vsta;                                // frame blank rise
		coord_t vmax;                                // frame length
		coord_t hsize;
		coord_t vsize;
	} raster_geom_t;

	typedef struct packed {
		coord_t hbl_l;
		coord_t hbl_r;
		coord_t vbl_t;
		coord_t vbl_b;
	} crop_t;

	typedef struct packed {
		crop_t      crop;
		coord_t     hsize;
		coord_t     vsize;
		logic [1:0] res;
	} mode_snapshot_t;

endpackage
